// File: common/sched_cfg_pkg.sv
`default_nettype none

package sched_cfg_pkg;

  // Ethernet ports and processing cores
  localparam int PORT_COUNT = 2;
  localparam int PORT_W     = 1;
  localparam int CORE_COUNT = 4;
  localparam int CORE_W     = 2;

  // Slot numbers run from 1 to SLOT_COUNT
  localparam int SLOT_COUNT = 8;
  localparam int SLOT_W     = 4;
  localparam int SLOT_PTR_W = 3;

  localparam int DATA_W = 64;
  localparam int KEEP_W = 8;

  localparam int MSG_TYPE_W = 4;
  localparam logic [MSG_TYPE_W-1:0] MSG_SLOT_RET  = 4'd0;
  localparam logic [MSG_TYPE_W-1:0] MSG_SLOT_INIT = 4'd3;

  // Host register map
  localparam int REG_ADDR_W = 5;
  localparam int WB_DATA_W  = 32;
  localparam logic [REG_ADDR_W-1:0] REG_ENABLED     = 5'h00;
  localparam logic [REG_ADDR_W-1:0] REG_INCOME      = 5'h01;
  localparam logic [REG_ADDR_W-1:0] REG_FLUSH       = 5'h02;
  localparam logic [REG_ADDR_W-1:0] REG_SLOT_COUNT  = 5'h03;
  localparam logic [REG_ADDR_W-1:0] REG_SELECT      = 5'h04;
  localparam logic [REG_ADDR_W-1:0] REG_PORT_STATUS = 5'h10;
  localparam logic [REG_ADDR_W-1:0] REG_RELEASE     = 5'h12;
  localparam logic [WB_DATA_W-1:0]  RD_UNMAPPED     = 32'hFEFE_FEFE;

endpackage

`default_nettype wire

// File: common/sched_msg_pkg.sv
`default_nettype none

package sched_msg_pkg;

  // Destination of a packet on the core side
  typedef struct packed {
    logic [sched_cfg_pkg::CORE_W-1:0] core;
    logic [sched_cfg_pkg::SLOT_W-1:0] slot;
  } dest_tag_t;

  typedef struct packed {
    logic [sched_cfg_pkg::DATA_W-1:0] data;
    logic [sched_cfg_pkg::KEEP_W-1:0] keep;
    logic                             last;
  } rx_beat_t;

  // Slot field is a count for init and a slot number for return
  typedef struct packed {
    logic [sched_cfg_pkg::MSG_TYPE_W-1:0] msg_type;
    logic [sched_cfg_pkg::SLOT_W-1:0]     slot;
    logic [sched_cfg_pkg::CORE_W-1:0]     src_core;
  } ctrl_msg_t;

  typedef struct packed {
    logic                                 cyc;
    logic                                 stb;
    logic                                 we;
    logic [sched_cfg_pkg::REG_ADDR_W-1:0] adr;
    logic [sched_cfg_pkg::WB_DATA_W-1:0]  dat;
  } wb_req_t;

  typedef struct packed {
    logic                                ack;
    logic [sched_cfg_pkg::WB_DATA_W-1:0] dat;
  } wb_rsp_t;

  // Per-port descriptor state
  typedef enum logic [1:0] {
    STALL = 2'b00,
    FIRST = 2'b01,
    WAIT  = 2'b10,
    MID   = 2'b11
  } port_state_t;

endpackage

`default_nettype wire

// File: logic/slot_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module slot_keeper (
  input  logic                             clk,
  input  logic                             rst_r,
  input  logic                             flush,
  input  logic                             init_valid,
  input  logic [sched_cfg_pkg::SLOT_W-1:0] init_count,
  input  logic                             enq_valid,
  input  logic [sched_cfg_pkg::SLOT_W-1:0] enq_slot,
  input  logic                             pop,
  output logic [sched_cfg_pkg::SLOT_W-1:0] head,
  output logic                             head_valid,
  output logic [sched_cfg_pkg::SLOT_W-1:0] count,
  output logic                             enq_err
);
  import sched_cfg_pkg::*;

  logic [SLOT_W-1:0]     mem [SLOT_COUNT];
  logic [SLOT_PTR_W-1:0] rd_ptr;
  logic [SLOT_PTR_W-1:0] wr_ptr;
  logic [SLOT_W-1:0]     init_n;
  logic                  full;
  logic                  do_enq;

  assign full       = (count == SLOT_W'(SLOT_COUNT));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  // A pop in the same cycle frees room for the enqueue
  assign do_enq  = enq_valid && (!full || pop);
  assign enq_err = enq_valid && full && !pop;

  // Larger init requests are capped at the pool size
  assign init_n = (init_count > SLOT_W'(SLOT_COUNT)) ? SLOT_W'(SLOT_COUNT) : init_count;

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= init_n[SLOT_PTR_W-1:0];
      count  <= init_n;
    end else begin
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_enq)
        wr_ptr <= wr_ptr + 1'b1;
      count <= count + {{(SLOT_W-1){1'b0}}, do_enq} - {{(SLOT_W-1){1'b0}}, pop};
    end
  end

  // Init lays out slots 1..SLOT_COUNT in order
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < SLOT_COUNT; i++)
        mem[i] <= SLOT_W'(i + 1);
    end else if (do_enq) begin
      mem[wr_ptr] <= enq_slot;
    end
  end

  // The picker must only choose a core that still holds a slot
  a_pop_not_empty: assert property (@(posedge clk) disable iff (rst_r)
    pop |-> head_valid);

endmodule

`default_nettype wire

// File: logic/core_picker.sv
`timescale 1ns/1ps
`default_nettype none

module core_picker (
  input  logic [sched_cfg_pkg::SLOT_W-1:0]     counts [sched_cfg_pkg::CORE_COUNT],
  input  logic [sched_cfg_pkg::CORE_COUNT-1:0] income,
  output logic [sched_cfg_pkg::CORE_W-1:0]     pick_core,
  output logic                                 pick_valid
);
  import sched_cfg_pkg::*;

  logic [SLOT_W-1:0] masked [CORE_COUNT];
  logic [SLOT_W-1:0] val_l1 [CORE_COUNT/2];
  logic [CORE_W-1:0] idx_l1 [CORE_COUNT/2];
  logic [SLOT_W-1:0] best;

  // Cores outside the income mask count as empty
  always_comb begin
    for (int c = 0; c < CORE_COUNT; c++)
      masked[c] = income[c] ? counts[c] : '0;
  end

  // Upper entry only wins when strictly larger, so ties keep the lower index
  always_comb begin
    for (int p = 0; p < CORE_COUNT/2; p++) begin
      if (masked[2*p+1] > masked[2*p]) begin
        val_l1[p] = masked[2*p+1];
        idx_l1[p] = CORE_W'(2*p + 1);
      end else begin
        val_l1[p] = masked[2*p];
        idx_l1[p] = CORE_W'(2*p);
      end
    end
  end

  always_comb begin
    if (val_l1[1] > val_l1[0]) begin
      best      = val_l1[1];
      pick_core = idx_l1[1];
    end else begin
      best      = val_l1[0];
      pick_core = idx_l1[0];
    end
    pick_valid = (best != '0);
  end

endmodule

`default_nettype wire

// File: rx_assign/rx_port_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module rx_port_fsm (
  input  logic                      clk,
  input  logic                      rst_r,
  input  logic                      rx_valid,
  input  logic                      rx_last,
  input  logic                      data_ready,
  input  logic                      granted,
  input  sched_msg_pkg::dest_tag_t  new_tag,
  input  logic                      release_desc,
  output logic                      desc_req,
  output logic                      pass,
  output sched_msg_pkg::dest_tag_t  dest,
  output sched_msg_pkg::port_state_t state,
  output sched_msg_pkg::dest_tag_t  prefetch
);
  import sched_msg_pkg::*;

  dest_tag_t pkt_tag;
  logic      beat;
  logic      beat_last;

  assign pass      = (state != STALL);
  assign beat      = rx_valid && data_ready && pass;
  assign beat_last = beat && rx_last;

  // Grant comes back in the same cycle, so only ask while no descriptor is held
  assign desc_req = (state == STALL) || (state == WAIT);

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state <= STALL;
    end else begin
      case (state)
        STALL: begin
          if (granted)
            state <= FIRST;
        end
        FIRST: begin
          if (beat_last)
            state <= STALL;
          else if (beat)
            state <= WAIT;
          else if (release_desc)
            state <= STALL;
        end
        WAIT: begin
          if (granted && beat_last)
            state <= FIRST;
          else if (granted)
            state <= MID;
          else if (beat_last)
            state <= STALL;
        end
        MID: begin
          if (beat_last)
            state <= release_desc ? STALL : FIRST;
          // Prefetched descriptor is given up
          else if (release_desc)
            state <= WAIT;
        end
        default: state <= STALL;
      endcase
    end
  end

  // Prefetch fills on grant, the packet tag on its first beat
  always_ff @(posedge clk) begin
    if (granted)
      prefetch <= new_tag;
    if ((state == FIRST) && beat)
      pkt_tag <= prefetch;
  end

  assign dest = (state == FIRST) ? prefetch : pkt_tag;

endmodule

`default_nettype wire

// File: rx_assign/rx_assign.sv
`timescale 1ns/1ps
`default_nettype none

module rx_assign (
  input  logic                                 clk,
  input  logic                                 rst_r,
  input  logic [sched_cfg_pkg::PORT_COUNT-1:0] rx_valid,
  input  logic [sched_cfg_pkg::PORT_COUNT-1:0] rx_last,
  input  logic [sched_cfg_pkg::PORT_COUNT-1:0] data_ready,
  input  logic [sched_cfg_pkg::PORT_COUNT-1:0] release_desc,
  input  logic                                 pick_valid,
  input  logic [sched_cfg_pkg::CORE_W-1:0]     pick_core,
  input  logic [sched_cfg_pkg::SLOT_W-1:0]     heads [sched_cfg_pkg::CORE_COUNT],
  output logic                                 desc_pop,
  output logic [sched_cfg_pkg::CORE_W-1:0]     desc_core,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0] pass,
  output sched_msg_pkg::dest_tag_t             dest [sched_cfg_pkg::PORT_COUNT],
  output sched_msg_pkg::port_state_t           states [sched_cfg_pkg::PORT_COUNT],
  output sched_msg_pkg::dest_tag_t             prefetch [sched_cfg_pkg::PORT_COUNT]
);
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  logic [PORT_COUNT-1:0] desc_req;
  logic [PORT_COUNT-1:0] granted;
  logic [PORT_W-1:0]     rr_ptr;
  logic [PORT_W-1:0]     grant_port;
  logic [PORT_W-1:0]     idx;
  logic                  grant_any;
  dest_tag_t             new_tag;

  // Round robin starting from rr_ptr
  always_comb begin
    grant_any  = 1'b0;
    grant_port = rr_ptr;
    idx        = rr_ptr;
    for (int i = 0; i < PORT_COUNT; i++) begin
      idx = rr_ptr + PORT_W'(i);
      if (!grant_any && desc_req[idx]) begin
        grant_any  = 1'b1;
        grant_port = idx;
      end
    end
  end

  assign desc_pop  = grant_any && pick_valid;
  assign desc_core = pick_core;
  assign granted   = desc_pop ? ({{(PORT_COUNT-1){1'b0}}, 1'b1} << grant_port) : '0;
  assign new_tag   = '{core: pick_core, slot: heads[pick_core]};

  always_ff @(posedge clk) begin
    if (rst_r)
      rr_ptr <= '0;
    else if (desc_pop)
      rr_ptr <= grant_port + PORT_W'(1);
  end

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
    rx_port_fsm u_port (
      .clk         (clk),
      .rst_r       (rst_r),
      .rx_valid    (rx_valid[p]),
      .rx_last     (rx_last[p]),
      .data_ready  (data_ready[p]),
      .granted     (granted[p]),
      .new_tag     (new_tag),
      .release_desc(release_desc[p]),
      .desc_req    (desc_req[p]),
      .pass        (pass[p]),
      .dest        (dest[p]),
      .state       (states[p]),
      .prefetch    (prefetch[p])
    );
  end

  // At most one port takes a descriptor per cycle
  a_single_grant: assert property (@(posedge clk) disable iff (rst_r)
    $onehot0($past(desc_req) & ~desc_req));

endmodule

`default_nettype wire

// File: logic/host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module host_regs (
  input  logic                                 clk,
  input  logic                                 rst_r,
  input  sched_msg_pkg::wb_req_t               wb_req,
  output sched_msg_pkg::wb_rsp_t               wb_rsp,
  input  logic [sched_cfg_pkg::SLOT_W-1:0]     counts [sched_cfg_pkg::CORE_COUNT],
  input  sched_msg_pkg::port_state_t           states [sched_cfg_pkg::PORT_COUNT],
  input  sched_msg_pkg::dest_tag_t             prefetch [sched_cfg_pkg::PORT_COUNT],
  output logic [sched_cfg_pkg::CORE_COUNT-1:0] enabled,
  output logic [sched_cfg_pkg::CORE_COUNT-1:0] income,
  output logic [sched_cfg_pkg::CORE_COUNT-1:0] flush,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0] release_desc
);
  import sched_cfg_pkg::*;

  logic                 ack_r;
  logic                 access;
  logic [WB_DATA_W-1:0] rd_data_r;
  logic [WB_DATA_W-1:0] rd_mux;
  logic [CORE_W-1:0]    sel_r;
  logic [PORT_W-1:0]    port_sel;

  // No access in the ack cycle so a held request is taken once
  assign access   = wb_req.cyc && wb_req.stb && !ack_r;
  assign port_sel = sel_r[PORT_W-1:0];

  always_comb begin
    case (wb_req.adr)
      REG_ENABLED:     rd_mux = WB_DATA_W'(enabled);
      REG_INCOME:      rd_mux = WB_DATA_W'(income);
      REG_SELECT:      rd_mux = WB_DATA_W'(sel_r);
      REG_SLOT_COUNT:  rd_mux = WB_DATA_W'(counts[sel_r]);
      REG_PORT_STATUS: rd_mux = {14'd0, states[port_sel], 6'd0, prefetch[port_sel].core,
                                 4'd0, prefetch[port_sel].slot};
      default:         rd_mux = RD_UNMAPPED;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      ack_r        <= 1'b0;
      enabled      <= '0;
      income       <= '0;
      flush        <= '0;
      release_desc <= '0;
      sel_r        <= '0;
    end else begin
      ack_r        <= access;
      flush        <= '0;
      release_desc <= '0;
      if (access && wb_req.we) begin
        case (wb_req.adr)
          REG_ENABLED: begin
            // A disabled core stops being incoming too
            enabled <= wb_req.dat[CORE_COUNT-1:0];
            income  <= income & wb_req.dat[CORE_COUNT-1:0];
          end
          REG_INCOME:  income       <= wb_req.dat[CORE_COUNT-1:0] & enabled;
          REG_FLUSH:   flush        <= wb_req.dat[CORE_COUNT-1:0];
          REG_SELECT:  sel_r        <= wb_req.dat[CORE_W-1:0];
          REG_RELEASE: release_desc <= wb_req.dat[PORT_COUNT-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access)
      rd_data_r <= rd_mux;
  end

  assign wb_rsp = '{ack: ack_r, dat: rd_data_r};

  // Master holds stb until it sees ack
  a_ack_with_stb: assert property (@(posedge clk) disable iff (rst_r)
    wb_rsp.ack |-> wb_req.stb);

endmodule

`default_nettype wire

// File: logic/pkt_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_scheduler (
  input  logic                                 clk,
  input  logic                                 rst_r,
  input  sched_msg_pkg::rx_beat_t              rx_beat [sched_cfg_pkg::PORT_COUNT],
  input  logic [sched_cfg_pkg::PORT_COUNT-1:0] rx_valid,
  output logic [sched_cfg_pkg::PORT_COUNT-1:0] rx_ready,
  output sched_msg_pkg::rx_beat_t              data_beat [sched_cfg_pkg::PORT_COUNT],
  output sched_msg_pkg::dest_tag_t             data_dest [sched_cfg_pkg::PORT_COUNT],
  output logic [sched_cfg_pkg::PORT_COUNT-1:0] data_valid,
  input  logic [sched_cfg_pkg::PORT_COUNT-1:0] data_ready,
  input  logic                                 ctrl_valid,
  input  sched_msg_pkg::ctrl_msg_t             ctrl_msg,
  input  sched_msg_pkg::wb_req_t               wb_req,
  output sched_msg_pkg::wb_rsp_t               wb_rsp
);
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  logic [CORE_COUNT-1:0] init_v;
  logic [CORE_COUNT-1:0] enq_v;
  logic [CORE_COUNT-1:0] pop;
  logic [CORE_COUNT-1:0] head_valid;
  logic [CORE_COUNT-1:0] flush;
  logic [CORE_COUNT-1:0] enabled;
  logic [CORE_COUNT-1:0] income;
  logic [SLOT_W-1:0]     msg_slot_r;
  logic [SLOT_W-1:0]     heads [CORE_COUNT];
  logic [SLOT_W-1:0]     counts [CORE_COUNT];
  logic                  pick_valid;
  logic                  desc_pop;
  logic [CORE_W-1:0]     pick_core;
  logic [CORE_W-1:0]     desc_core;
  logic [PORT_COUNT-1:0] rx_last;
  logic [PORT_COUNT-1:0] pass;
  logic [PORT_COUNT-1:0] release_desc;
  port_state_t           states [PORT_COUNT];
  dest_tag_t             prefetch [PORT_COUNT];

  // Control messages become per-core strobes one cycle later
  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_v <= '0;
      enq_v  <= '0;
    end else begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        init_v[c] <= ctrl_valid && (ctrl_msg.msg_type == MSG_SLOT_INIT) &&
                     (ctrl_msg.src_core == CORE_W'(c));
        enq_v[c]  <= ctrl_valid && (ctrl_msg.msg_type == MSG_SLOT_RET) &&
                     (ctrl_msg.src_core == CORE_W'(c));
      end
    end
  end

  always_ff @(posedge clk) begin
    msg_slot_r <= ctrl_msg.slot;
  end

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_core
    assign pop[c] = desc_pop && (desc_core == CORE_W'(c));

    slot_keeper u_keeper (
      .clk       (clk),
      .rst_r     (rst_r),
      .flush     (flush[c]),
      .init_valid(init_v[c]),
      .init_count(msg_slot_r),
      .enq_valid (enq_v[c]),
      .enq_slot  (msg_slot_r),
      .pop       (pop[c]),
      .head      (heads[c]),
      .head_valid(head_valid[c]),
      .count     (counts[c]),
      .enq_err   ()
    );
  end

  // Candidates are enabled incoming cores with a slot at the head
  core_picker u_picker (
    .counts    (counts),
    .income    (income & enabled & head_valid),
    .pick_core (pick_core),
    .pick_valid(pick_valid)
  );

  rx_assign u_assign (
    .clk         (clk),
    .rst_r       (rst_r),
    .rx_valid    (rx_valid),
    .rx_last     (rx_last),
    .data_ready  (data_ready),
    .release_desc(release_desc),
    .pick_valid  (pick_valid),
    .pick_core   (pick_core),
    .heads       (heads),
    .desc_pop    (desc_pop),
    .desc_core   (desc_core),
    .pass        (pass),
    .dest        (data_dest),
    .states      (states),
    .prefetch    (prefetch)
  );

  host_regs u_host (
    .clk         (clk),
    .rst_r       (rst_r),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .counts      (counts),
    .states      (states),
    .prefetch    (prefetch),
    .enabled     (enabled),
    .income      (income),
    .flush       (flush),
    .release_desc(release_desc)
  );

  // Zero-latency data path, closed off while the port is stalled
  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_data
    assign rx_last[p]    = rx_beat[p].last;
    assign data_beat[p]  = rx_beat[p];
    assign data_valid[p] = rx_valid[p] && pass[p];
    assign rx_ready[p]   = data_ready[p] && pass[p];
  end

endmodule

`default_nettype wire

// File: bench/tb_pkt_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_scheduler;
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  localparam int HALF         = 20;
  localparam int PERIOD       = 2 * HALF;
  localparam int RESET_CYCLES = 4;
  localparam int PKTS_A       = 6;
  localparam int PKTS_B       = 8;
  localparam int MAX_LEN      = 8;
  localparam int PKT_TOTAL    = PORT_COUNT * (PKTS_A + PKTS_B);
  localparam int WATCH_CYCLES = PKT_TOTAL * MAX_LEN * 20 + 2000;

  logic                  clk = 1'b0;
  logic                  rst_r;
  rx_beat_t              rx_beat [PORT_COUNT];
  logic [PORT_COUNT-1:0] rx_valid;
  logic [PORT_COUNT-1:0] rx_ready;
  rx_beat_t              data_beat [PORT_COUNT];
  dest_tag_t             data_dest [PORT_COUNT];
  logic [PORT_COUNT-1:0] data_valid;
  logic [PORT_COUNT-1:0] data_ready;
  logic                  ctrl_valid;
  ctrl_msg_t             ctrl_msg;
  wb_req_t               wb_req;
  wb_rsp_t               wb_rsp;

  // Reference model state
  bit          free_slot [CORE_COUNT][16];
  ctrl_msg_t   msg_q [$];
  logic [3:0]  allow_mask;
  int          ban_core;
  int          ban_from [PORT_COUNT];
  int          pkt_no [PORT_COUNT];
  integer      seed;
  integer      port_seed [PORT_COUNT];
  integer      msg_seed;

  pkt_scheduler dut (
    .clk       (clk),
    .rst_r     (rst_r),
    .rx_beat   (rx_beat),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .data_beat (data_beat),
    .data_dest (data_dest),
    .data_valid(data_valid),
    .data_ready(data_ready),
    .ctrl_valid(ctrl_valid),
    .ctrl_msg  (ctrl_msg),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp)
  );

  always #(HALF) clk = ~clk;

  initial begin
    #(WATCH_CYCLES * PERIOD);
    $display("Timeout: the run did not complete within the expected time");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic rand_next(inout integer s, output integer r);
    r = $random(s);
  endtask

  task automatic wb_access(input logic we, input logic [REG_ADDR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    #(HALF - 1);
    while (!wb_rsp.ack)
      #(PERIOD);
    rdat = wb_rsp.dat;
    @(negedge clk);
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [REG_ADDR_W-1:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input logic [REG_ADDR_W-1:0] adr, output logic [31:0] rdat);
    wb_access(1'b0, adr, 32'd0, rdat);
  endtask

  task automatic read_slot_count(input int c, output logic [31:0] cnt);
    wb_write(REG_SELECT, 32'(c));
    wb_read(REG_SLOT_COUNT, cnt);
  endtask

  // Wait until every queued control message has reached the pools
  task automatic wait_msgs_drained();
    while (msg_q.size() != 0 || ctrl_valid)
      @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  task automatic init_core(input int c, input int n);
    msg_q.push_back('{msg_type: MSG_SLOT_INIT, slot: 4'(n), src_core: 2'(c)});
    for (int sl = 0; sl < 16; sl++)
      free_slot[c][sl] = (sl >= 1) && (sl <= n);
  endtask

  task automatic check_new_tag(input int p, input dest_tag_t tag);
    int c;
    int sl;
    c  = int'(tag.core);
    sl = int'(tag.slot);
    check_value("tag_core_incoming", 128'(allow_mask[c]), 128'(1));
    if (ban_core >= 0 && pkt_no[p] >= ban_from[p])
      check_value("tag_core_after_disable", 128'(c == ban_core), 128'(0));
    // A tag still out with another packet is no longer free
    check_value("tag_slot_free", 128'(free_slot[c][sl]), 128'(1));
    free_slot[c][sl] = 1'b0;
  endtask

  task automatic send_packet(input int p, inout integer s);
    rx_beat_t  beat;
    dest_tag_t tag;
    integer    r;
    int        len;
    bit        sent;
    rand_next(s, r);
    len = 1 + int'(r[2:0]);
    tag = '0;
    for (int i = 0; i < len; i++) begin
      rand_next(s, r);
      beat.data[63:32] = r;
      rand_next(s, r);
      beat.data[31:0] = r;
      beat.last = (i == len - 1);
      beat.keep = beat.last ? (8'hFF >> r[2:0]) : 8'hFF;
      sent = 1'b0;
      while (!sent) begin
        @(negedge clk);
        rand_next(s, r);
        rx_valid[p]   = (r[1:0] != 2'b00);
        data_ready[p] = (r[4:2] != 3'b000);
        rx_beat[p]    = beat;
        #(HALF - 1);
        // Back-pressure passes straight through
        if (!data_ready[p])
          check_value("rx_ready", 128'(rx_ready[p]), 128'(0));
        // A beat leaves exactly when it is taken in
        check_value("data_xfer", 128'(data_valid[p] && data_ready[p]),
                    128'(rx_valid[p] && rx_ready[p]));
        if (rx_valid[p] && rx_ready[p]) begin
          check_value("data_valid", 128'(data_valid[p]), 128'(1));
          check_value("data_beat", 128'(data_beat[p]), 128'(beat));
          if (i == 0) begin
            tag = data_dest[p];
            check_new_tag(p, tag);
          end else begin
            check_value("data_dest", 128'(data_dest[p]), 128'(tag));
          end
          sent = 1'b1;
        end
      end
    end
    msg_q.push_back('{msg_type: MSG_SLOT_RET, slot: tag.slot, src_core: tag.core});
    pkt_no[p]++;
  endtask

  task automatic run_port(input int p, input int npkt);
    integer s;
    s = port_seed[p];
    for (int k = 0; k < npkt; k++)
      send_packet(p, s);
    port_seed[p] = s;
    @(negedge clk);
    rx_valid[p]   = 1'b0;
    data_ready[p] = 1'b1;
  endtask

  // Control message sender with random gaps, shared by inits and returns
  initial begin
    ctrl_msg_t m;
    integer    r;
    ctrl_valid = 1'b0;
    ctrl_msg   = '0;
    forever begin
      @(negedge clk);
      ctrl_valid = 1'b0;
      if (msg_q.size() != 0) begin
        rand_next(msg_seed, r);
        repeat (r[1:0]) @(negedge clk);
        m = msg_q.pop_front();
        if (m.msg_type == MSG_SLOT_RET)
          free_slot[m.src_core][m.slot] = 1'b1;
        ctrl_msg   = m;
        ctrl_valid = 1'b1;
      end
    end
  end

  initial begin
    logic [31:0] rd;
    logic [3:0]  en;
    logic [3:0]  inc;
    logic [3:0]  exp_inc;
    int          n [CORE_COUNT];
    integer      r;

    seed         = 32'hf825_fb6b;
    port_seed[0] = seed ^ 1;
    port_seed[1] = seed ^ 2;
    msg_seed     = seed ^ 3;
    rst_r        = 1'b1;
    rx_valid     = '0;
    data_ready   = '0;
    rx_beat[0]   = '0;
    rx_beat[1]   = '0;
    wb_req       = '0;
    ban_core     = -1;
    allow_mask   = '0;
    for (int p = 0; p < PORT_COUNT; p++) begin
      pkt_no[p]   = 0;
      ban_from[p] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_r = 1'b0;

    // State after reset
    #(HALF - 1);
    check_value("rx_ready", 128'(rx_ready), 128'(0));
    check_value("data_valid", 128'(data_valid), 128'(0));
    wb_read(REG_ENABLED, rd);
    check_value("reg_enabled", 128'(rd), 128'(0));
    wb_read(REG_INCOME, rd);
    check_value("reg_income", 128'(rd), 128'(0));
    wb_read(5'h1F, rd);
    check_value("reg_unmapped", 128'(rd), 128'(32'hFEFE_FEFE));

    // Income is always a subset of enabled
    exp_inc = '0;
    for (int k = 0; k < 8; k++) begin
      rand_next(seed, r);
      en      = r[3:0];
      inc     = r[7:4];
      exp_inc = exp_inc & en;
      wb_write(REG_ENABLED, 32'(en));
      wb_read(REG_INCOME, rd);
      check_value("reg_income", 128'(rd), 128'(exp_inc));
      wb_write(REG_INCOME, 32'(inc));
      exp_inc = inc & en;
      wb_read(REG_INCOME, rd);
      check_value("reg_income", 128'(rd), 128'(exp_inc));
      wb_read(REG_ENABLED, rd);
      check_value("reg_enabled", 128'(rd), 128'(en));
    end

    // Pools with no incoming core, so nothing is prefetched
    wb_write(REG_ENABLED, 32'hF);
    wb_write(REG_INCOME, 32'h0);
    for (int c = 0; c < CORE_COUNT; c++) begin
      rand_next(seed, r);
      n[c] = 1 + int'(r[7:0]) % 7;
      init_core(c, n[c]);
    end
    wait_msgs_drained();
    for (int c = 0; c < CORE_COUNT; c++) begin
      read_slot_count(c, rd);
      check_value("slot_count", 128'(rd), 128'(n[c]));
      msg_q.push_back('{msg_type: MSG_SLOT_RET, slot: 4'd8, src_core: 2'(c)});
    end
    wait_msgs_drained();
    for (int c = 0; c < CORE_COUNT; c++) begin
      read_slot_count(c, rd);
      check_value("slot_count", 128'(rd), 128'(n[c] + 1));
    end

    // Fresh pools for traffic, with at least two incoming cores
    for (int c = 0; c < CORE_COUNT; c++) begin
      rand_next(seed, r);
      init_core(c, 4 + int'(r[7:0]) % 5);
    end
    wait_msgs_drained();
    inc = '0;
    while ($countones(inc) < 2) begin
      rand_next(seed, r);
      inc = r[3:0];
    end
    allow_mask = inc;
    wb_write(REG_INCOME, 32'(inc));

    fork
      run_port(0, PKTS_A);
      run_port(1, PKTS_A);
    join
    wait_msgs_drained();

    // Drop the lowest incoming core while another one stays incoming
    for (int c = CORE_COUNT - 1; c >= 0; c--) begin
      if (inc[c])
        ban_core = c;
    end
    wb_write(REG_INCOME, 32'(inc & ~(4'd1 << ban_core)));
    for (int p = 0; p < PORT_COUNT; p++)
      ban_from[p] = pkt_no[p] + 2;

    fork
      run_port(0, PKTS_B);
      run_port(1, PKTS_B);
    join
    wait_msgs_drained();

    // Flush every pool
    wb_write(REG_INCOME, 32'h0);
    wb_write(REG_FLUSH, 32'hF);
    repeat (2) @(negedge clk);
    for (int c = 0; c < CORE_COUNT; c++) begin
      read_slot_count(c, rd);
      check_value("slot_count", 128'(rd), 128'(0));
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
common/sched_cfg_pkg.sv
common/sched_msg_pkg.sv
logic/slot_keeper.sv
logic/core_picker.sv
rx_assign/rx_port_fsm.sv
rx_assign/rx_assign.sv
logic/host_regs.sv
logic/pkt_scheduler.sv
bench/tb_pkt_scheduler.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pkt_scheduler
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' list.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
